// File: src/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // ------------------------------
  // Basic widths
  // ------------------------------

  // Address or instruction word of RV32
  typedef logic [31:0] xlen_t;

  // Major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  // ------------------------------
  // Control-flow classes
  // ------------------------------

  // Kind of control transfer found by the predecoder
  typedef enum logic [1:0] {
    // Sequential instruction
    CF_NONE   = 2'b00,
    // Conditional branch, static direction
    CF_BRANCH = 2'b01,
    // Direct jump (JAL)
    CF_JUMP   = 2'b10,
    // Indirect jump (JALR), target unknown here
    CF_JUMPR  = 2'b11
  } cf_e;

  // Static prediction attached to one entry, 34 bits
  typedef struct packed {
    cf_e   cf;
    xlen_t predict_addr;
  } bp_t;

  // One instruction queue entry, 98 bits
  typedef struct packed {
    // Fetch address of the word
    xlen_t pc;
    // Raw instruction word
    xlen_t inst;
    // Class and predicted next address
    bp_t   bp;
  } frontend_t;

  // ------------------------------
  // Opcodes seen by the predecoder
  // ------------------------------

  // BEQ, BNE, BLT, BGE, BLTU, BGEU
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // Jump and link, PC-relative
  localparam opcode_t OPC_JAL    = 7'b1101111;

  // Jump and link register
  localparam opcode_t OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// File: src/fetch_if.sv
`default_nettype none

interface fetch_if
  import ooo_pkg::*;
();

  // Word offered this cycle
  logic  valid;
  // Address of the word
  xlen_t pc;
  // Raw instruction bits
  xlen_t inst;
  // Predecoded class
  cf_e   cf;
  // Static next-address guess
  xlen_t predict_addr;
  // Queue has room, level only
  logic  ready;

  // Predecoder side
  modport producer (
    output valid, pc, inst, cf, predict_addr,
    input  ready
  );

  // Instruction queue side
  modport consumer (
    input  valid, pc, inst, cf, predict_addr,
    output ready
  );

endinterface

`default_nettype wire

// File: src/frontend_fifo.sv
`default_nettype none

module frontend_fifo
  import ooo_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic      clock,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      push_i,
  input  frontend_t data_i,
  input  logic      pop_i,
  output frontend_t data_o,
  output logic      full_o,
  output logic      empty_o
);

  // Pointer and occupancy widths
  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // Last slot index and full level
  localparam ptr_t LAST_PTR = ptr_t'(QUEUE_DEPTH - 1);
  localparam cnt_t FULL_CNT = cnt_t'(QUEUE_DEPTH);

  // Entry storage
  frontend_t mem [QUEUE_DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;

  // Step a pointer, wrap also for depths that are no power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == LAST_PTR) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_t'(1);
    end
    return nxt;
  endfunction

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      // Flush wins over push and pop
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Count only moves when exactly one side is active
      unique case ({push_i, pop_i})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // Storage write
  // ------------------------------
  always_ff @(posedge clock) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Head is read straight from the array, no fall-through
  assign data_o  = mem[rd_ptr];

  // Status from the registered count
  assign full_o  = (count == FULL_CNT);
  assign empty_o = (count == '0);

  // The queue above gates push and pop with these flags
  a_no_push_full: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    push_i |-> !full_o
  ) else $error("frontend_fifo: push while full");

  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    pop_i |-> !empty_o
  ) else $error("frontend_fifo: pop while empty");

endmodule

`default_nettype wire

// File: src/predecode.sv
`default_nettype none

module predecode
  import ooo_pkg::*;
(
  input  logic  instr_valid_i,
  input  xlen_t instr_i,
  input  xlen_t addr_i,
  fetch_if.producer fetch
);

  // Decoded fields
  opcode_t opcode;
  xlen_t   imm_j;
  xlen_t   imm_b;

  // Candidate next addresses
  xlen_t   pc_plus4;
  xlen_t   pc_jal;
  xlen_t   pc_branch;

  // Classification result
  cf_e     cf;
  xlen_t   predict_addr;

  // ------------------------------
  // Field extraction
  // ------------------------------
  assign opcode = instr_i[6:0];

  // J-type immediate, bit 0 always zero
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // B-type immediate, bit 0 always zero
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // Sequential and PC-relative targets
  assign pc_plus4  = addr_i + xlen_t'(4);
  assign pc_jal    = addr_i + imm_j;
  assign pc_branch = addr_i + imm_b;

  // ------------------------------
  // Static prediction
  // ------------------------------
  always_comb begin
    cf           = CF_NONE;
    predict_addr = pc_plus4;
    unique case (opcode)
      OPC_JAL: begin
        // Direct jump, target fully known
        cf           = CF_JUMP;
        predict_addr = pc_jal;
      end
      OPC_BRANCH: begin
        cf = CF_BRANCH;
        // Backward taken, forward not taken
        if (imm_b[31]) begin
          predict_addr = pc_branch;
        end else begin
          predict_addr = pc_plus4;
        end
      end
      OPC_JALR: begin
        // No return stack, fall through
        cf           = CF_JUMPR;
        predict_addr = pc_plus4;
      end
      default: begin
        cf           = CF_NONE;
        predict_addr = pc_plus4;
      end
    endcase
  end

  // ------------------------------
  // Drive the fetch bus
  // ------------------------------
  assign fetch.valid        = instr_valid_i;
  assign fetch.pc           = addr_i;
  assign fetch.inst         = instr_i;
  assign fetch.cf           = cf;
  assign fetch.predict_addr = predict_addr;

endmodule

`default_nettype wire

// File: src/inst_queue.sv
`default_nettype none

module inst_queue
  import ooo_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic      clock,
  input  logic      rst_n_i,
  input  logic      flush_i,
  fetch_if.consumer fetch,
  output logic      push_o,
  output logic      replay_o,
  output xlen_t     replay_addr_o,
  output frontend_t frontend_data_o,
  output logic      frontend_valid_o,
  input  logic      backend_ready_i
);

  // FIFO side
  frontend_t fifo_in;
  frontend_t fifo_out;
  logic      fifo_push;
  logic      fifo_pop;
  logic      fifo_full;
  logic      fifo_empty;

  // ------------------------------
  // Upstream side
  // ------------------------------

  // Pack the bus into one entry
  assign fifo_in.pc              = fetch.pc;
  assign fifo_in.inst            = fetch.inst;
  assign fifo_in.bp.cf           = fetch.cf;
  assign fifo_in.bp.predict_addr = fetch.predict_addr;

  // Room as of the last edge, a pop this cycle does not count
  assign fetch.ready = ~fifo_full;

  // Words during a flush are lost without replay
  assign fifo_push = fetch.valid & ~fifo_full & ~flush_i;
  assign push_o    = fifo_push;

  // ------------------------------
  // Replay
  // ------------------------------

  // Overflowing word is dropped, fetch must resend it
  assign replay_o      = fetch.valid & fifo_full & ~flush_i;
  assign replay_addr_o = fetch.pc;

  // ------------------------------
  // Downstream side
  // ------------------------------
  assign frontend_valid_o = ~fifo_empty;
  assign frontend_data_o  = fifo_out;
  assign fifo_pop         = frontend_valid_o & backend_ready_i;

  frontend_fifo #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_frontend_fifo (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .push_i  (fifo_push),
    .data_i  (fifo_in),
    .pop_i   (fifo_pop),
    .data_o  (fifo_out),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  // A replayed word never reaches storage, so a full queue without a pop stays full
  a_replay_not_stored: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    (replay_o && !fifo_pop) |=> fifo_full
  ) else $error("inst_queue: replayed word entered the queue");

  // Stalled head holds its value into the next cycle
  a_head_stable: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    (frontend_valid_o && !backend_ready_i && !flush_i)
      |=> (frontend_valid_o && $stable(frontend_data_o))
  ) else $error("inst_queue: head changed under back-pressure");

endmodule

`default_nettype wire

// File: src/ooo_frontend.sv
`default_nettype none

module ooo_frontend
  import ooo_pkg::*;
#(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic  clock,
  input  logic  rst_n_i,
  input  logic  flush_i,
  // Fetch side
  input  logic  instr_valid_i,
  input  xlen_t instr_i,
  input  xlen_t addr_i,
  output logic  ready_o,
  output logic  push_o,
  output logic  replay_o,
  output xlen_t replay_addr_o,
  // Backend side
  output logic  fe_valid_o,
  output xlen_t fe_pc_o,
  output xlen_t fe_instr_o,
  output cf_e   fe_cf_o,
  output xlen_t fe_predict_addr_o,
  input  logic  backend_ready_i
);

  // Head entry of the queue
  frontend_t frontend_data;

  // Predecoder to queue
  fetch_if u_fetch_if ();

  // ------------------------------
  // Predecoder
  // ------------------------------
  predecode u_predecode (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .addr_i        (addr_i),
    .fetch         (u_fetch_if.producer)
  );

  // ------------------------------
  // Instruction queue
  // ------------------------------
  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_inst_queue (
    .clock            (clock),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .fetch            (u_fetch_if.consumer),
    .push_o           (push_o),
    .replay_o         (replay_o),
    .replay_addr_o    (replay_addr_o),
    .frontend_data_o  (frontend_data),
    .frontend_valid_o (fe_valid_o),
    .backend_ready_i  (backend_ready_i)
  );

  // Readiness seen by the fetch unit
  assign ready_o = u_fetch_if.ready;

  // Flatten the head entry
  assign fe_pc_o           = frontend_data.pc;
  assign fe_instr_o        = frontend_data.inst;
  assign fe_cf_o           = frontend_data.bp.cf;
  assign fe_predict_addr_o = frontend_data.bp.predict_addr;

endmodule

`default_nettype wire

// File: verification/tb_ooo_frontend.sv
`default_nettype none

module tb_ooo_frontend
  import ooo_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int QUEUE_DEPTH = 4;

  // One table row, the stimulus and the predecode result it should give
  typedef struct {
    int    test;
    logic  valid;
    xlen_t instr;
    xlen_t addr;
    logic  bready;
    logic  flush;
    cf_e   cf;
    xlen_t pred;
  } row_t;

  logic  clock;
  logic  rst_n_i;
  logic  flush_i;
  logic  instr_valid_i;
  xlen_t instr_i;
  xlen_t addr_i;
  logic  backend_ready_i;
  logic  ready_o;
  logic  push_o;
  logic  replay_o;
  xlen_t replay_addr_o;
  logic  fe_valid_o;
  xlen_t fe_pc_o;
  xlen_t fe_instr_o;
  cf_e   fe_cf_o;
  xlen_t fe_predict_addr_o;

  row_t        rows[$];
  // Expected queue contents, head at index 0
  frontend_t   model_q[$];
  logic [31:0] lfsr_state;
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          timeout_limit;

  ooo_frontend #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clock             (clock),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .instr_valid_i     (instr_valid_i),
    .instr_i           (instr_i),
    .addr_i            (addr_i),
    .ready_o           (ready_o),
    .push_o            (push_o),
    .replay_o          (replay_o),
    .replay_addr_o     (replay_addr_o),
    .fe_valid_o        (fe_valid_o),
    .fe_pc_o           (fe_pc_o),
    .fe_instr_o        (fe_instr_o),
    .fe_cf_o           (fe_cf_o),
    .fe_predict_addr_o (fe_predict_addr_o),
    .backend_ready_i   (backend_ready_i)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic xlen_t rand_word(input int n);
    xlen_t w;
    w = '0;
    for (int k = 0; k < n; k++) begin
      w = {w[30:0], rand_bit()};
    end
    return w;
  endfunction

  // Encoders, immediates given as full 32-bit values
  function automatic xlen_t jal_word(input xlen_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic xlen_t branch_word(input xlen_t imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic xlen_t jalr_word();
    return {12'h000, 5'd1, 3'b000, 5'd0, OPC_JALR};
  endfunction

  // ADDI x3, x3, imm
  function automatic xlen_t alu_word(input xlen_t imm);
    return {imm[11:0], 5'd3, 3'b000, 5'd3, 7'b0010011};
  endfunction

  task automatic add_row(input int test, input logic valid, input xlen_t instr,
                         input xlen_t addr, input logic bready, input logic flush,
                         input cf_e cf, input xlen_t pred);
    row_t r;
    r = '{test, valid, instr, addr, bready, flush, cf, pred};
    rows.push_back(r);
  endtask

  // Plain ALU word, sequential next address
  task automatic add_alu(input int test, input logic valid, input xlen_t addr,
                         input logic bready, input logic flush);
    add_row(test, valid, alu_word(addr), addr, bready, flush, CF_NONE, addr + 32'd4);
  endtask

  task automatic add_idle(input int test, input logic bready);
    add_row(test, 1'b0, '0, '0, bready, 1'b0, CF_NONE, '0);
  endtask

  task automatic build_table();
    xlen_t pc;
    logic  v;
    logic  b;
    xlen_t a;
    pc = 32'h0000_1000;
    // Predecode, one word of each class with the backend always ready
    add_row(2, 1'b1, jal_word(32'h0000_0800), pc, 1'b1, 1'b0, CF_JUMP, pc + 32'h0000_0800);
    pc = pc + 32'd4;
    add_row(2, 1'b1, jal_word(32'hffff_ff00), pc, 1'b1, 1'b0, CF_JUMP, pc - 32'd256);
    pc = pc + 32'd4;
    // Forward branch not taken, backward taken
    add_row(2, 1'b1, branch_word(32'h0000_0040), pc, 1'b1, 1'b0, CF_BRANCH, pc + 32'd4);
    pc = pc + 32'd4;
    add_row(2, 1'b1, branch_word(32'hffff_ffe0), pc, 1'b1, 1'b0, CF_BRANCH, pc - 32'd32);
    pc = pc + 32'd4;
    add_row(2, 1'b1, jalr_word(), pc, 1'b1, 1'b0, CF_JUMPR, pc + 32'd4);
    pc = pc + 32'd4;
    add_alu(2, 1'b1, pc, 1'b1, 1'b0);
    pc = pc + 32'd4;
    add_idle(2, 1'b1);
    // Order, a flowing burst then a held burst drained later
    for (int k = 0; k < 6; k++) begin
      add_alu(3, 1'b1, pc, k < 3, 1'b0);
      pc = pc + 32'd4;
    end
    add_idle(3, 1'b1);
    add_idle(3, 1'b1);
    add_idle(3, 1'b1);
    add_idle(3, 1'b1);
    // Back-pressure, fill then overflow into replay
    for (int k = 0; k < QUEUE_DEPTH + 2; k++) begin
      add_alu(4, 1'b1, pc, 1'b0, 1'b0);
      pc = pc + 32'd4;
    end
    add_idle(4, 1'b0);
    for (int k = 0; k <= QUEUE_DEPTH; k++) begin
      add_idle(4, 1'b1);
    end
    // Flush with a word in flight, then fresh pushes
    add_alu(5, 1'b1, pc, 1'b0, 1'b0);
    add_alu(5, 1'b1, pc + 32'd4, 1'b0, 1'b0);
    add_alu(5, 1'b1, pc + 32'd8, 1'b0, 1'b1);
    add_idle(5, 1'b0);
    add_alu(5, 1'b1, pc + 32'd12, 1'b1, 1'b0);
    add_alu(5, 1'b1, pc + 32'd16, 1'b1, 1'b0);
    add_idle(5, 1'b1);
    add_idle(5, 1'b1);
    // Random stream, word-aligned addresses
    for (int k = 0; k < 48; k++) begin
      v = rand_bit();
      b = rand_bit();
      a = rand_word(30) << 2;
      add_alu(6, v, a, b, 1'b0);
    end
    for (int k = 0; k <= QUEUE_DEPTH; k++) begin
      add_idle(6, 1'b1);
    end
  endtask

  // ------------------------------
  // Checking
  // ------------------------------
  task automatic compare(input xlen_t actual, input xlen_t expected, input string what);
    if (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Outputs mid-cycle against the model, then the edge effect on it
  task automatic check_row(input row_t r);
    logic      room;
    logic      exp_push;
    logic      exp_replay;
    logic      exp_pop;
    frontend_t e;
    room       = (model_q.size() < QUEUE_DEPTH);
    exp_push   = r.valid && room && !r.flush;
    exp_replay = r.valid && !room && !r.flush;
    exp_pop    = (model_q.size() != 0) && r.bready && !r.flush;
    compare(xlen_t'(ready_o), xlen_t'(room), "ready_o");
    compare(xlen_t'(push_o), xlen_t'(exp_push), "push_o");
    compare(xlen_t'(replay_o), xlen_t'(exp_replay), "replay_o");
    if (exp_replay) begin
      compare(replay_addr_o, r.addr, "replay_addr_o");
    end
    compare(xlen_t'(fe_valid_o), xlen_t'(model_q.size() != 0), "fe_valid_o");
    if (model_q.size() != 0) begin
      compare(fe_pc_o, model_q[0].pc, "fe_pc_o");
      compare(fe_instr_o, model_q[0].inst, "fe_instr_o");
      compare(xlen_t'(fe_cf_o), xlen_t'(model_q[0].bp.cf), "fe_cf_o");
      compare(fe_predict_addr_o, model_q[0].bp.predict_addr, "fe_predict_addr_o");
    end
    if (r.flush) begin
      model_q.delete();
    end else begin
      if (exp_pop) begin
        void'(model_q.pop_front());
      end
      if (exp_push) begin
        e.pc              = r.addr;
        e.inst            = r.instr;
        e.bp.cf           = r.cf;
        e.bp.predict_addr = r.pred;
        model_q.push_back(e);
      end
    end
  endtask

  function automatic string test_title(input int n);
    case (n)
      1:       return "reset state";
      2:       return "predecode";
      3:       return "order and latency";
      4:       return "back-pressure and replay";
      5:       return "flush";
      default: return "random stream";
    endcase
  endfunction

  task automatic report_test(input int n, input int errs);
    $display("Test %0d, %s: %0d mismatches", n, test_title(n), errs);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int cur_test;
    int fails_at_start;
    rst_n_i         <= 1'b0;
    flush_i         <= 1'b0;
    instr_valid_i   <= 1'b0;
    instr_i         <= '0;
    addr_i          <= '0;
    backend_ready_i <= 1'b0;
    lfsr_state    = 32'hac9d_98de;
    pass_count    = 0;
    fail_count    = 0;
    build_table();
    timeout_limit = rows.size() + QUEUE_DEPTH + 64;
    repeat (16) @(posedge clock);
    rst_n_i <= 1'b1;
    @(negedge clock);
    compare(xlen_t'(fe_valid_o), 32'd0, "fe_valid_o after reset");
    compare(xlen_t'(push_o), 32'd0, "push_o after reset");
    compare(xlen_t'(replay_o), 32'd0, "replay_o after reset");
    compare(xlen_t'(ready_o), 32'd1, "ready_o after reset");
    report_test(1, fail_count);
    cur_test       = rows[0].test;
    fails_at_start = fail_count;
    foreach (rows[i]) begin
      if (rows[i].test != cur_test) begin
        report_test(cur_test, fail_count - fails_at_start);
        cur_test       = rows[i].test;
        fails_at_start = fail_count;
      end
      @(posedge clock);
      instr_valid_i   <= rows[i].valid;
      instr_i         <= rows[i].instr;
      addr_i          <= rows[i].addr;
      backend_ready_i <= rows[i].bready;
      flush_i         <= rows[i].flush;
      @(negedge clock);
      check_row(rows[i]);
    end
    report_test(cur_test, fail_count - fails_at_start);
    $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Run limit from the table length
  initial begin
    cycle_count = 0;
    @(posedge clock);
    while (cycle_count < timeout_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/ooo_pkg.sv
src/fetch_if.sv
src/frontend_fifo.sv
src/predecode.sv
src/inst_queue.sv
src/ooo_frontend.sv
verification/tb_ooo_frontend.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_ooo_frontend

# Compile the design and testbench from the file list
verilator --binary --timing --assert -f tb.f --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Run and keep the output for inspection
"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Result comes from the log
if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG_FILE"; then
  echo "No result line found in $LOG_FILE"
  exit 1
fi
exit 0
